/* Makefile */
VERILATOR  = verilator
TOP        = sta_tb
FILELIST   = compile.f
FLAGS      = --binary --timing --assert --timescale 1ns/10ps
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/10ps
RUN_ARGS   = +verilator+error+limit+100
OBJ_DIR    = obj_dir
PASS_MSG   = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+.
sta_pkg.sv
sta_ctrl_if.sv
sta_cmd_decode.sv
tensor_process_elem.sv
systolic_tensor_array.sv
sta_output_requant.sv
sta_top.sv
sta_sva.sv
sta_tb.sv

/* sta_cmd_decode.sv */
`timescale 1ns/10ps
`include "sta_defs.svh"

module sta_cmd_decode
    import sta_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cmd_valid,
    input  sta_cmd_t                cmd_word,
    output logic                    busy,
    sta_ctrl_if.ctrl                ctrl,
    output logic                    read_req,
    output logic [`STA_SHIFT_W-1:0] read_shift
);

    // Remaining cycles of the current run burst
    logic [`STA_RUN_W-1:0] run_cnt;

    // Command taken this edge
    logic accept;
    logic [`STA_OP_W-1:0] opcode;

    // Registered bias load, one cycle after acceptance
    logic [`STA_N-1:0][`STA_N-1:0] lb_strobe;
    logic [`STA_IDX_W-1:0] lb_row;
    logic [`STA_IDX_W-1:0] lb_col;
    int32_t lb_value;

    // Opcode sits in the same bits of both views
    assign opcode = cmd_word.ctrl.opcode;

    // Commands that arrive during a run are dropped
    assign accept = cmd_valid && !busy;

    // Non-zero counter means the array runs
    assign busy = (run_cnt != '0);

    // ====================
    // Control state
    // ====================

    always_ff @(posedge clk) begin
        if (reset) begin
            run_cnt   <= '0;
            lb_strobe <= '0;
            read_req  <= 1'b0;
        end else begin
            // Strobes last one cycle
            lb_strobe <= '0;
            read_req  <= 1'b0;

            // Count down the burst; never overlaps acceptance
            if (busy) begin
                run_cnt <= run_cnt - 1'b1;
            end

            if (accept) begin
                case (opcode)
                    `STA_OP_NOP: begin
                        // Nothing to do
                    end
                    `STA_OP_BIAS: begin
                        lb_strobe[cmd_word.bias.row][cmd_word.bias.col] <= 1'b1;
                    end
                    `STA_OP_RUN: begin
                        // Zero length leaves busy low, same as a NOP
                        run_cnt <= cmd_word.ctrl.run_len;
                    end
                    `STA_OP_READ: begin
                        read_req <= 1'b1;
                    end
                endcase
            end
        end
    end

    // ====================
    // Command payload
    // ====================

    always_ff @(posedge clk) begin
        // Bias view
        if (accept && opcode == `STA_OP_BIAS) begin
            lb_row   <= cmd_word.bias.row;
            lb_col   <= cmd_word.bias.col;
            lb_value <= int32_t'(cmd_word.bias.bias);
        end
        // Control view, shift travels with read_req
        if (accept && opcode == `STA_OP_READ) begin
            read_shift <= cmd_word.ctrl.shift;
        end
    end

    // Array control
    assign ctrl.stall      = !busy;
    assign ctrl.load_bias  = lb_strobe;
    assign ctrl.bias_row   = lb_row;
    assign ctrl.bias_col   = lb_col;
    assign ctrl.bias_value = lb_value;

endmodule

/* sta_ctrl_if.sv */
`timescale 1ns/10ps
`include "sta_defs.svh"

interface sta_ctrl_if
    import sta_pkg::*;
();

    // Array freeze level, high whenever no run burst is active
    logic stall;

    // One strobe per PE, indexed [row][col], at most one bit set
    logic [`STA_N-1:0][`STA_N-1:0] load_bias;

    // Address of the PE that the current strobe targets
    logic [`STA_IDX_W-1:0] bias_row;
    logic [`STA_IDX_W-1:0] bias_col;

    // Sign-extended bias for the addressed PE
    int32_t bias_value;

    // Decoder side
    modport ctrl (
        output stall,
        output load_bias,
        output bias_row,
        output bias_col,
        output bias_value
    );

    // Array side
    modport pe (
        input stall,
        input load_bias,
        input bias_row,
        input bias_col,
        input bias_value
    );

endinterface

/* sta_defs.svh */
`ifndef STA_DEFS_SVH
`define STA_DEFS_SVH

// ====================
// Array geometry
// ====================

// PE grid is STA_N rows by STA_N columns
`define STA_N 4
// Total PE count, also the length of the flattened result buses
`define STA_PES (`STA_N * `STA_N)
// Elements per edge vector, one dot product per PE per cycle
`define STA_VW 4

// ====================
// Command word
// ====================

// Opcodes in bits [31:30]
`define STA_OP_NOP  2'd0
`define STA_OP_BIAS 2'd1
`define STA_OP_RUN  2'd2
`define STA_OP_READ 2'd3

// Field widths
`define STA_OP_W    2
`define STA_IDX_W   2
`define STA_BIAS_W  26
`define STA_SHIFT_W 5
`define STA_RUN_W   16

`endif

/* sta_output_requant.sv */
`timescale 1ns/10ps
`include "sta_defs.svh"

module sta_output_requant
    import sta_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    read_req,
    input  logic [`STA_SHIFT_W-1:0] read_shift,
    input  int32_t [`STA_PES-1:0]   acc,
    output int8_t [`STA_PES-1:0]    q_out,
    output logic                    q_valid
);

    // Saturated results, ready for the next read_req
    int8_t [`STA_PES-1:0] q_next;

    // ====================
    // Shift and clamp
    // ====================

    always_comb begin
        int32_t shifted;

        for (int i = 0; i < `STA_PES; i++) begin
            // Arithmetic shift keeps the sign
            shifted = $signed(acc[i]) >>> read_shift;

            // Clamp to the int8 range
            if (shifted > 32'sd127) begin
                q_next[i] = 8'sd127;
            end else if (shifted < -32'sd128) begin
                q_next[i] = -8'sd128;
            end else begin
                q_next[i] = shifted[7:0];
            end
        end
    end

    // Results hold until the next readout
    always_ff @(posedge clk) begin
        if (read_req) begin
            q_out <= q_next;
        end
    end

    // One pulse per readout
    always_ff @(posedge clk) begin
        if (reset) begin
            q_valid <= 1'b0;
        end else begin
            q_valid <= read_req;
        end
    end

endmodule

/* sta_pkg.sv */
`include "sta_defs.svh"

package sta_pkg;

    // ====================
    // Element types
    // ====================

    // Signed int8 operand
    typedef logic signed [7:0] int8_t;

    // Signed accumulator word
    typedef logic signed [31:0] int32_t;

    // One edge vector, element 0 sits in the low byte
    typedef int8_t [`STA_VW-1:0] vec8_t;

    // ====================
    // Command word views
    // ====================

    // BIAS view, opcode 1
    // Bias is signed and gets sign-extended to the accumulator width
    typedef struct packed {
        logic [`STA_OP_W-1:0]          opcode;
        logic [`STA_IDX_W-1:0]         row;
        logic [`STA_IDX_W-1:0]         col;
        logic signed [`STA_BIAS_W-1:0] bias;
    } sta_bias_view_t;

    // Control view, opcodes 2 and 3
    // RUN reads run_len, READ reads shift
    typedef struct packed {
        logic [`STA_OP_W-1:0]    opcode;
        logic [8:0]              rsvd;
        logic [`STA_SHIFT_W-1:0] shift;
        logic [`STA_RUN_W-1:0]   run_len;
    } sta_ctrl_view_t;

    // Same 32 bits seen both ways, opcode lines up in both views
    typedef union packed {
        sta_bias_view_t bias;
        sta_ctrl_view_t ctrl;
    } sta_cmd_t;

endpackage

/* sta_sva.sv */
`timescale 1ns/10ps
`include "sta_defs.svh"

module sta_sva
    import sta_pkg::*;
(
    input logic                clk,
    input logic                reset,
    input logic                cmd_valid,
    input logic [31:0]         cmd_word,
    input logic                busy,
    input logic                q_valid,
    input logic                sta_idle,
    input logic [`STA_PES-1:0] load_bias
);

    // Failed assertions so far, polled by the testbench
    int fail_count = 0;

    logic accept;
    logic accept_run;
    logic accept_read;

    // Cycles left in the burst that the last RUN asked for
    logic [`STA_RUN_W-1:0] busy_left;

    assign accept      = cmd_valid && !busy;
    assign accept_run  = accept && (cmd_word[31:30] == `STA_OP_RUN);
    assign accept_read = accept && (cmd_word[31:30] == `STA_OP_READ);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_left <= '0;
        end else if (accept_run) begin
            busy_left <= cmd_word[15:0];
        end else if (busy_left != '0) begin
            busy_left <= busy_left - 16'd1;
        end
    end

    // ====================
    // Properties
    // ====================

    // Quiet state right after reset
    reset_state: assert property (@(posedge clk)
        $fell(reset) |-> !busy && !q_valid && sta_idle && (load_bias == '0))
        else begin
            fail_count = fail_count + 1;
            $error("outputs not in reset state after reset");
        end

    // Readout pulse two cycles after acceptance
    read_pulse: assert property (@(posedge clk) disable iff (reset)
        accept_read |-> ##2 q_valid)
        else begin
            fail_count = fail_count + 1;
            $error("q_valid missing two cycles after READ");
        end

    // No pulse without a READ and never longer than one cycle
    read_source: assert property (@(posedge clk) disable iff (reset)
        q_valid |-> $past(accept_read, 2))
        else begin
            fail_count = fail_count + 1;
            $error("q_valid high without a READ two cycles earlier");
        end

    // Busy for exactly the run length
    busy_length: assert property (@(posedge clk) disable iff (reset)
        busy == (busy_left != '0))
        else begin
            fail_count = fail_count + 1;
            $error("busy does not match the accepted run length");
        end

    // Bias strobes
    bias_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(load_bias))
        else begin
            fail_count = fail_count + 1;
            $error("more than one load_bias strobe active");
        end

    bias_one_cycle: assert property (@(posedge clk) disable iff (reset)
        (load_bias != '0) |=> ((load_bias & $past(load_bias)) == '0))
        else begin
            fail_count = fail_count + 1;
            $error("load_bias strobe held for more than one cycle");
        end

endmodule

/* sta_tb.sv */
`timescale 1ns/10ps
`include "sta_defs.svh"

module sta_tb
    import sta_pkg::*;
();

    logic                  clk;
    logic                  reset;
    logic                  cmd_valid;
    logic [31:0]           cmd_word;
    vec8_t [`STA_N-1:0]    a_vec;
    vec8_t [`STA_N-1:0]    b_vec;
    logic                  busy;
    int32_t [`STA_PES-1:0] c_acc;
    int8_t [`STA_PES-1:0]  q_out;
    logic                  q_valid;
    logic                  sta_idle;

    // Fibonacci LFSR state with taps x^16 + x^14 + x^13 + x^11
    logic [15:0] lfsr = 16'd24006;

    // Reference model state
    vec8_t  m_fa [`STA_N][`STA_N];
    vec8_t  m_fb [`STA_N][`STA_N];
    int32_t m_acc [`STA_PES];
    int8_t  m_q [`STA_PES];
    int     m_run;
    int     m_lb_pe;
    int32_t m_lb_val;
    int     m_rd_shift;
    logic   m_lb;
    logic   m_rd;
    logic   m_qv;

    // Set once q_out holds a readout
    logic   m_q_ok;

    // Set once sta_idle has been seen low
    logic idle_seen_low;

    sta_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_word  (cmd_word),
        .a_vec     (a_vec),
        .b_vec     (b_vec),
        .busy      (busy),
        .c_acc     (c_acc),
        .q_out     (q_out),
        .q_valid   (q_valid),
        .sta_idle  (sta_idle)
    );

    bind sta_top sta_sva i_sva (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_word  (cmd_word),
        .busy      (busy),
        .q_valid   (q_valid),
        .sta_idle  (sta_idle),
        .load_bias (i_ctrl_if.load_bias)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ====================
    // Helpers
    // ====================

    function automatic logic next_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] bias_word(input int row, input int col,
                                              input logic [25:0] val);
        return {`STA_OP_BIAS, row[1:0], col[1:0], val};
    endfunction

    function automatic logic [31:0] ctrl_word(input logic [1:0] op,
                                              input logic [4:0] shift,
                                              input logic [15:0] len);
        return {op, 9'd0, shift, len};
    endfunction

    // Signed dot product of two edge vectors
    function automatic int32_t dot4(input vec8_t x, input vec8_t y);
        int32_t s;
        s = 0;
        for (int k = 0; k < `STA_VW; k++) begin
            s = s + int32_t'(x[k]) * int32_t'(y[k]);
        end
        return s;
    endfunction

    // Arithmetic shift then clamp to int8
    function automatic int8_t requant(input int32_t v, input int s);
        int32_t t;
        t = v >>> s;
        if (t > 127) begin
            return int8_t'(127);
        end
        if (t < -128) begin
            return int8_t'(-128);
        end
        return int8_t'(t);
    endfunction

    function automatic logic model_idle();
        logic idle;
        idle = !m_lb;
        for (int i = 0; i < `STA_N; i++) begin
            if (a_vec[i] != '0 || b_vec[i] != '0) begin
                idle = 1'b0;
            end
        end
        for (int r = 0; r < `STA_N; r++) begin
            for (int c = 0; c < `STA_N; c++) begin
                if (m_fa[r][c] != '0 || m_fb[r][c] != '0) begin
                    idle = 1'b0;
                end
            end
        end
        return idle;
    endfunction

    // ====================
    // Reference model
    // ====================

    task automatic model_step();
        logic  stall;
        logic  accept;
        vec8_t ai;
        vec8_t bi;
        int    p;
        stall  = (m_run == 0);
        accept = cmd_valid && (m_run == 0);
        if (reset) begin
            for (int r = 0; r < `STA_N; r++) begin
                for (int c = 0; c < `STA_N; c++) begin
                    m_fa[r][c] = '0;
                    m_fb[r][c] = '0;
                    m_acc[r*`STA_N + c] = 0;
                end
            end
            m_run  = 0;
            m_lb   = 1'b0;
            m_rd   = 1'b0;
            m_qv   = 1'b0;
            m_q_ok = 1'b0;
        end else begin
            // Readout takes the sums from before this edge
            m_qv = m_rd;
            if (m_rd) begin
                for (int i = 0; i < `STA_PES; i++) begin
                    m_q[i] = requant(m_acc[i], m_rd_shift);
                end
                m_q_ok = 1'b1;
            end
            m_rd = 1'b0;
            // Walk from the far corner so neighbors still hold old data
            for (int r = `STA_N - 1; r >= 0; r--) begin
                for (int c = `STA_N - 1; c >= 0; c--) begin
                    p = r * `STA_N + c;
                    if (c == 0) begin
                        ai = a_vec[r];
                    end else begin
                        ai = m_fa[r][c-1];
                    end
                    if (r == 0) begin
                        bi = b_vec[c];
                    end else begin
                        bi = m_fb[r-1][c];
                    end
                    if (m_lb && m_lb_pe == p) begin
                        m_acc[p] = m_lb_val;
                    end else if (!stall) begin
                        m_acc[p] = m_acc[p] + dot4(ai, bi);
                    end
                    if (!stall) begin
                        m_fa[r][c] = ai;
                        m_fb[r][c] = bi;
                    end
                end
            end
            m_lb = 1'b0;
            if (m_run != 0) begin
                m_run = m_run - 1;
            end
            if (accept) begin
                case (cmd_word[31:30])
                    `STA_OP_BIAS: begin
                        m_lb     = 1'b1;
                        m_lb_pe  = int'(cmd_word[29:28]) * `STA_N + int'(cmd_word[27:26]);
                        m_lb_val = {{6{cmd_word[25]}}, cmd_word[25:0]};
                    end
                    `STA_OP_RUN: m_run = int'(cmd_word[15:0]);
                    `STA_OP_READ: begin
                        m_rd       = 1'b1;
                        m_rd_shift = int'(cmd_word[20:16]);
                    end
                    default: begin
                    end
                endcase
            end
        end
    endtask

    always @(posedge clk) begin
        model_step();
    end

    // ====================
    // Checks
    // ====================

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int32_t got, input int32_t expected);
        assert (got === expected) else begin
            fail_now($sformatf("error at %0d ns: %s is %0d, expected %0d",
                               $time, name, got, expected));
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        for (int i = 0; i < `STA_PES; i++) begin
            check_value($sformatf("c_acc[%0d]", i), c_acc[i], m_acc[i]);
        end
        check_value("busy", int32_t'(busy), int32_t'(m_run != 0));
        check_value("q_valid", int32_t'(q_valid), int32_t'(m_qv));
        // q_out must hold the last readout between READs
        if (m_q_ok) begin
            for (int i = 0; i < `STA_PES; i++) begin
                check_value($sformatf("q_out[%0d]", i), int32_t'(q_out[i]), int32_t'(m_q[i]));
            end
        end
        check_value("sta_idle", int32_t'(sta_idle), int32_t'(model_idle()));
        if (!sta_idle) begin
            idle_seen_low = 1'b1;
        end
        if (i_dut.i_sva.fail_count != 0) begin
            fail_now("a concurrent assertion in sta_sva failed");
        end
    end

    // ====================
    // Stimulus
    // ====================

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_cmd(input logic [31:0] word);
        cmd_valid = 1'b1;
        cmd_word  = word;
        next_cycle();
        cmd_valid = 1'b0;
        cmd_word  = '0;
    endtask

    task automatic drive_random_edges();
        for (int i = 0; i < `STA_N; i++) begin
            a_vec[i] = vec8_t'(rand_bits(32));
            b_vec[i] = vec8_t'(rand_bits(32));
        end
    endtask

    // Data held on a stalled array must not be consumed
    task automatic stalled_gap(input int n);
        for (int i = 0; i < n; i++) begin
            drive_random_edges();
            next_cycle();
        end
    endtask

    task automatic wait_not_busy(input int limit);
        int n;
        n = 0;
        while (busy) begin
            if (n == limit) begin
                fail_now("timeout waiting for busy to drop");
            end
            next_cycle();
            n++;
        end
    endtask

    // RUN burst with fresh data every cycle and an optional dropped command
    task automatic run_burst(input int len, input logic poke);
        int n;
        logic [31:0] rv;
        send_cmd(ctrl_word(`STA_OP_RUN, 5'd0, len[15:0]));
        n = 0;
        while (busy) begin
            if (n == len + 4) begin
                fail_now("timeout waiting for a run burst to end");
            end
            drive_random_edges();
            cmd_valid = 1'b0;
            if (poke && n == 1) begin
                rv = rand_bits(26);
                cmd_valid = 1'b1;
                cmd_word  = bias_word(0, 0, rv[25:0]);
            end
            next_cycle();
            n++;
        end
        cmd_valid = 1'b0;
        cmd_word  = '0;
    endtask

    task automatic read_out(input logic [4:0] shift);
        int n;
        send_cmd(ctrl_word(`STA_OP_READ, shift, 16'd0));
        n = 0;
        while (!q_valid) begin
            if (n == 4) begin
                fail_now("timeout waiting for q_valid");
            end
            next_cycle();
            n++;
        end
        next_cycle();
    endtask

    initial begin
        logic [31:0] rv;
        reset         = 1'b1;
        cmd_valid     = 1'b0;
        cmd_word      = '0;
        a_vec         = '0;
        b_vec         = '0;
        idle_seen_low = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle();
        next_cycle();
        check_value("sta_idle", int32_t'(sta_idle), 1);

        // Bias every PE back to back
        for (int r = 0; r < `STA_N; r++) begin
            for (int c = 0; c < `STA_N; c++) begin
                rv = rand_bits(26);
                send_cmd(bias_word(r, c, rv[25:0]));
            end
        end
        next_cycle();
        next_cycle();

        // Bursts with stalled gaps where odd ones try a command while busy
        for (int k = 0; k < 8; k++) begin
            run_burst(1 + int'(rand_bits(4)), k[0]);
            stalled_gap(1 + int'(rand_bits(2)));
        end
        run_burst(5, 1'b1);
        run_burst(3, 1'b0);

        // Zero length run leaves busy low
        send_cmd(ctrl_word(`STA_OP_RUN, 5'd0, 16'd0));
        check_value("busy", int32_t'(busy), 0);

        // Readout at several shifts
        a_vec = '0;
        b_vec = '0;
        read_out(5'd0);
        read_out(5'd8);
        read_out(5'd20);

        // Flush zeros through the grid
        send_cmd(ctrl_word(`STA_OP_RUN, 5'd0, 16'(2 * `STA_N)));
        wait_not_busy(2 * `STA_N + 4);
        next_cycle();
        check_value("sta_idle", int32_t'(sta_idle), 1);
        assert (idle_seen_low) else begin
            fail_now("sta_idle never went low while data was in flight");
        end
        read_out(5'd4);

        if (i_dut.i_sva.fail_count != 0) begin
            fail_now("a concurrent assertion in sta_sva failed");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

/* sta_top.sv */
`timescale 1ns/10ps
`include "sta_defs.svh"

module sta_top
    import sta_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmd_valid,
    input  logic [31:0]           cmd_word,
    input  vec8_t [`STA_N-1:0]    a_vec,
    input  vec8_t [`STA_N-1:0]    b_vec,
    output logic                  busy,
    output int32_t [`STA_PES-1:0] c_acc,
    output int8_t [`STA_PES-1:0]  q_out,
    output logic                  q_valid,
    output logic                  sta_idle
);

    // Decoder to requantizer
    logic                    read_req;
    logic [`STA_SHIFT_W-1:0] read_shift;

    // Decoder to array
    sta_ctrl_if i_ctrl_if ();

    // Command word enters as raw bits, the decoder picks the view
    sta_cmd_decode i_decode (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_word   (cmd_word),
        .busy       (busy),
        .ctrl       (i_ctrl_if.ctrl),
        .read_req   (read_req),
        .read_shift (read_shift)
    );

    systolic_tensor_array i_array (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (i_ctrl_if.pe),
        .a_edge   (a_vec),
        .b_edge   (b_vec),
        .acc      (c_acc),
        .sta_idle (sta_idle)
    );

    // Accumulators also feed the readout path
    sta_output_requant i_requant (
        .clk        (clk),
        .reset      (reset),
        .read_req   (read_req),
        .read_shift (read_shift),
        .acc        (c_acc),
        .q_out      (q_out),
        .q_valid    (q_valid)
    );

endmodule

/* systolic_tensor_array.sv */
`timescale 1ns/10ps
`include "sta_defs.svh"

module systolic_tensor_array
    import sta_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    sta_ctrl_if.pe                ctrl,
    input  vec8_t [`STA_N-1:0]    a_edge,
    input  vec8_t [`STA_N-1:0]    b_edge,
    output int32_t [`STA_PES-1:0] acc,
    output logic                  sta_idle
);

    // PE inputs, [row][col]
    vec8_t a_in  [`STA_N][`STA_N];
    vec8_t b_in  [`STA_N][`STA_N];

    // PE forwarding registers, [row][col]
    vec8_t a_out [`STA_N][`STA_N];
    vec8_t b_out [`STA_N][`STA_N];

    // Per-PE load after the address check
    logic [`STA_N-1:0][`STA_N-1:0] pe_load;

    // ====================
    // PE grid
    // ====================

    for (genvar r = 0; r < `STA_N; r++) begin : g_row
        for (genvar c = 0; c < `STA_N; c++) begin : g_col

            // A flows left to right, left column fed from the edge
            if (c == 0) begin : g_a_edge
                assign a_in[r][c] = a_edge[r];
            end else begin : g_a_chain
                assign a_in[r][c] = a_out[r][c-1];
            end

            // B flows top to bottom, top row fed from the edge
            if (r == 0) begin : g_b_edge
                assign b_in[r][c] = b_edge[c];
            end else begin : g_b_chain
                assign b_in[r][c] = b_out[r-1][c];
            end

            // Strobe must agree with the registered address
            // so a stray strobe bit never loads the wrong PE
            assign pe_load[r][c] = ctrl.load_bias[r][c]
                                   && (int'(ctrl.bias_row) == r)
                                   && (int'(ctrl.bias_col) == c);

            tensor_process_elem i_pe (
                .clk        (clk),
                .reset      (reset),
                .stall      (ctrl.stall),
                .load_bias  (pe_load[r][c]),
                .bias_in    (ctrl.bias_value),
                .left_in    (a_in[r][c]),
                .top_in     (b_in[r][c]),
                .right_out  (a_out[r][c]),
                .bottom_out (b_out[r][c]),
                .sum_out    (acc[r*`STA_N + c])
            );
        end
    end

    // ====================
    // Idle detection
    // ====================

    // No data anywhere in the grid and no pending bias load
    always_comb begin
        sta_idle = 1'b1;

        // Edge inputs
        for (int i = 0; i < `STA_N; i++) begin
            if (a_edge[i] != '0 || b_edge[i] != '0) begin
                sta_idle = 1'b0;
            end
        end

        // Every forwarding register, last row and column included
        for (int r = 0; r < `STA_N; r++) begin
            for (int c = 0; c < `STA_N; c++) begin
                if (a_out[r][c] != '0 || b_out[r][c] != '0) begin
                    sta_idle = 1'b0;
                end
            end
        end

        if (ctrl.load_bias != '0) begin
            sta_idle = 1'b0;
        end
    end

endmodule

/* tensor_process_elem.sv */
`timescale 1ns/10ps
`include "sta_defs.svh"

module tensor_process_elem
    import sta_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   stall,
    input  logic   load_bias,
    input  int32_t bias_in,
    input  vec8_t  left_in,
    input  vec8_t  top_in,
    output vec8_t  right_out,
    output vec8_t  bottom_out,
    output int32_t sum_out
);

    // Signed dot product of the two vectors seen this cycle
    int32_t dot;

    always_comb begin
        dot = '0;
        for (int k = 0; k < `STA_VW; k++) begin
            // Signed operands sign-extend the product to 32 bits
            dot = dot + $signed(left_in[k]) * $signed(top_in[k]);
        end
    end

    // Accumulator and the systolic forwarding stage
    always_ff @(posedge clk) begin
        if (reset) begin
            sum_out    <= '0;
            right_out  <= '0;
            bottom_out <= '0;
        end else begin
            // Bias preload wins over the add even while stalled
            if (load_bias) begin
                sum_out <= bias_in;
            end else if (!stall) begin
                sum_out <= sum_out + dot;
            end
            // Forward A right and B down on unstalled edges only
            if (!stall) begin
                right_out  <= left_in;
                bottom_out <= top_in;
            end
        end
    end

endmodule
